/* image_pkg.sv */
`default_nettype none

package image_pkg;

    // One pixel word, stored raw by the FIFO and split into channels by the FSM
    typedef union packed {
        logic [23:0] raw;
        struct packed {
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } rgb;
    } pixel_t;

    typedef logic [7:0]   gray_t;
    typedef logic [127:0] ddr_word_t;
    typedef logic [31:0]  ddr_addr_t;

    // Memory model
    localparam ddr_addr_t BASE_ADDRESS      = 32'h0100_0000;
    localparam int        SDRAM_DEPTH       = 64;
    localparam int        SDRAM_INDEX_WIDTH = $clog2(SDRAM_DEPTH);
    localparam int        SDRAM_LATENCY     = 4;
    localparam int        TIMER_WIDTH       = $clog2(SDRAM_LATENCY + 1);

    // FIFOs
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_ADDR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = FIFO_ADDR_WIDTH + 1;

    // Grayscale FSM state codes
    localparam int             STATE_WIDTH      = 3;
    localparam logic [2:0]     STATE_IDLE       = 3'd0;
    localparam logic [2:0]     STATE_WRITE      = 3'd1;
    localparam logic [2:0]     STATE_WRITE_WAIT = 3'd2;
    localparam logic [2:0]     STATE_READ       = 3'd3;
    localparam logic [2:0]     STATE_READ_WAIT  = 3'd4;
    localparam logic [2:0]     STATE_OUTPUT     = 3'd5;

endpackage

`default_nettype wire

/* pixel_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    import image_pkg::*;

    logic [WIDTH-1:0]            buffer [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0]  wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0]  rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;
    logic                        push;
    logic                        pop;

    // Requests that would overflow or underflow are dropped
    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    assign full  = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Show-ahead: oldest entry is always on the output
    assign dout = buffer[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            buffer[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* access_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module access_timer (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);

    import image_pkg::*;

    logic [TIMER_WIDTH-1:0] count;

    // Start loads the full latency; count runs down to zero afterwards.
    // Strobe in cycle c gives count == 1 in cycle c + SDRAM_LATENCY
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= TIMER_WIDTH'(SDRAM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // Last cycle of the countdown is the completion cycle
    assign done = (count == TIMER_WIDTH'(1));

endmodule

`default_nettype wire

/* sdram_model.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_model (
    input  logic                 clock,
    input  logic                 reset,
    input  image_pkg::ddr_addr_t sdram_address,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  image_pkg::ddr_word_t write_data,
    output image_pkg::ddr_word_t read_data,
    output logic                 write_complete,
    output logic                 read_complete
);

    import image_pkg::*;

    ddr_word_t                    memory [SDRAM_DEPTH];
    ddr_addr_t                    offset_address;
    logic [SDRAM_INDEX_WIDTH-1:0] index;
    logic [SDRAM_INDEX_WIDTH-1:0] read_index;
    logic                         write_pending;
    logic                         read_pending;
    logic                         accept_write;
    logic                         accept_read;
    logic                         timer_busy;
    logic                         timer_done;

    // Word index relative to the base; low bits give the modulo for a power-of-two depth
    assign offset_address = sdram_address - BASE_ADDRESS;
    assign index          = offset_address[SDRAM_INDEX_WIDTH-1:0];

    // One access at a time
    assign accept_write = wr_en & ~timer_busy;
    assign accept_read  = rd_en & ~wr_en & ~timer_busy;

    access_timer timer (
        .clock (clock),
        .reset (reset),
        .start (accept_write | accept_read),
        .busy  (timer_busy),
        .done  (timer_done)
    );

    // Writes land in the array right away, only the completion is delayed
    always_ff @(posedge clock) begin
        if (accept_write) begin
            memory[index] <= write_data;
        end
        if (accept_read) begin
            read_index <= index;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_pending <= 1'b0;
            read_pending  <= 1'b0;
        end else if (timer_done) begin
            write_pending <= 1'b0;
            read_pending  <= 1'b0;
        end else begin
            if (accept_write) begin
                write_pending <= 1'b1;
            end
            if (accept_read) begin
                read_pending <= 1'b1;
            end
        end
    end

    assign write_complete = timer_done & write_pending;
    assign read_complete  = timer_done & read_pending;

    // Addressed word stays on the bus until the next read latches a new index
    assign read_data = memory[read_index];

endmodule

`default_nettype wire

/* grayscale_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module grayscale_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_empty,
    input  image_pkg::pixel_t    in_dout,
    output logic                 in_rd_en,
    output image_pkg::ddr_addr_t sdram_address,
    output logic                 rd_en,
    output logic                 wr_en,
    output image_pkg::ddr_word_t write_data,
    input  logic                 write_complete,
    input  logic                 read_complete,
    input  image_pkg::ddr_word_t read_data,
    input  logic                 out_full,
    output logic                 out_wr_en,
    output image_pkg::gray_t     out_din
);

    import image_pkg::*;

    logic [STATE_WIDTH-1:0]       state;
    logic [STATE_WIDTH-1:0]       next_state;
    logic [SDRAM_INDEX_WIDTH-1:0] offset;
    logic [SDRAM_INDEX_WIDTH-1:0] offset_c;
    gray_t                        gray;
    gray_t                        gray_c;
    gray_t                        result;
    gray_t                        result_c;
    logic [9:0]                   channel_sum;

    // Three 8-bit channels need 10 bits before the divide
    assign channel_sum = {2'b00, in_dout.rgb.red}
                       + {2'b00, in_dout.rgb.green}
                       + {2'b00, in_dout.rgb.blue};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= STATE_IDLE;
            offset <= '0;
        end else begin
            state  <= next_state;
            offset <= offset_c;
        end
    end

    always_ff @(posedge clock) begin
        gray   <= gray_c;
        result <= result_c;
    end

    // Address and data stay on the bus; the strobes qualify them
    assign sdram_address = BASE_ADDRESS + ddr_addr_t'(offset);
    assign write_data    = ddr_word_t'(gray);
    assign out_din       = result;

    always_comb begin
        next_state = state;
        offset_c   = offset;
        gray_c     = gray;
        result_c   = result;
        in_rd_en   = 1'b0;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        out_wr_en  = 1'b0;

        case (state)
            STATE_IDLE: begin
                if (!in_empty) begin
                    gray_c     = gray_t'(channel_sum / 10'd3);
                    in_rd_en   = 1'b1;
                    next_state = STATE_WRITE;
                end
            end

            STATE_WRITE: begin
                wr_en      = 1'b1;
                next_state = STATE_WRITE_WAIT;
            end

            STATE_WRITE_WAIT: begin
                if (write_complete) begin
                    next_state = STATE_READ;
                end
            end

            // Same word is read back from memory
            STATE_READ: begin
                rd_en      = 1'b1;
                next_state = STATE_READ_WAIT;
            end

            STATE_READ_WAIT: begin
                if (read_complete) begin
                    result_c   = read_data[7:0];
                    next_state = STATE_OUTPUT;
                end
            end

            // Held here while the output FIFO is full
            STATE_OUTPUT: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    // Offset width wraps it at SDRAM_DEPTH
                    offset_c   = offset + 1'b1;
                    next_state = STATE_IDLE;
                end
            end

            default: begin
                next_state = STATE_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* grayscale_top.sv */
`timescale 1ns/10ps
`default_nettype none

module grayscale_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              in_wr_en,
    input  image_pkg::pixel_t in_din,
    output logic              in_full,
    input  logic              out_rd_en,
    output image_pkg::gray_t  out_dout,
    output logic              out_empty
);

    import image_pkg::*;

    // Input FIFO to FSM
    logic      in_rd_en;
    logic      in_empty;
    pixel_t    in_dout;

    // FSM to memory model
    ddr_addr_t sdram_address;
    logic      mem_rd_en;
    logic      mem_wr_en;
    ddr_word_t write_data;
    ddr_word_t read_data;
    logic      write_complete;
    logic      read_complete;

    // FSM to output FIFO
    logic      out_wr_en;
    gray_t     out_din;
    logic      out_full;

    pixel_fifo #(
        .WIDTH ($bits(pixel_t))
    ) input_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din.raw),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .full  (in_full),
        .empty (in_empty)
    );

    grayscale_fsm fsm (
        .clock          (clock),
        .reset          (reset),
        .in_empty       (in_empty),
        .in_dout        (in_dout),
        .in_rd_en       (in_rd_en),
        .sdram_address  (sdram_address),
        .rd_en          (mem_rd_en),
        .wr_en          (mem_wr_en),
        .write_data     (write_data),
        .write_complete (write_complete),
        .read_complete  (read_complete),
        .read_data      (read_data),
        .out_full       (out_full),
        .out_wr_en      (out_wr_en),
        .out_din        (out_din)
    );

    sdram_model memory (
        .clock          (clock),
        .reset          (reset),
        .sdram_address  (sdram_address),
        .wr_en          (mem_wr_en),
        .rd_en          (mem_rd_en),
        .write_data     (write_data),
        .read_data      (read_data),
        .write_complete (write_complete),
        .read_complete  (read_complete)
    );

    pixel_fifo #(
        .WIDTH ($bits(gray_t))
    ) output_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_din),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .full  (out_full),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

/* grayscale_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module grayscale_sva (
    input logic clock,
    input logic reset,
    input logic mem_rd_en,
    input logic mem_wr_en,
    input logic write_complete,
    input logic read_complete,
    input logic out_wr_en,
    input logic out_full
);

    import image_pkg::*;

    // Memory model serves one access at a time
    single_strobe: assert property (@(posedge clock) disable iff (reset)
        !(mem_rd_en && mem_wr_en))
        else $error("Memory read and write strobes are high in the same cycle");

    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        out_wr_en |-> !out_full)
        else $error("Push into the output FIFO while it is full");

    // Completion arrives a fixed latency after its strobe
    write_latency: assert property (@(posedge clock) disable iff (reset)
        write_complete |-> $past(mem_wr_en, SDRAM_LATENCY))
        else $error("write_complete without a write strobe %0d cycles before", SDRAM_LATENCY);

    read_latency: assert property (@(posedge clock) disable iff (reset)
        read_complete |-> $past(mem_rd_en, SDRAM_LATENCY))
        else $error("read_complete without a read strobe %0d cycles before", SDRAM_LATENCY);

endmodule

bind grayscale_top grayscale_sva protocol_checks (
    .clock          (clock),
    .reset          (reset),
    .mem_rd_en      (mem_rd_en),
    .mem_wr_en      (mem_wr_en),
    .write_complete (write_complete),
    .read_complete  (read_complete),
    .out_wr_en      (out_wr_en),
    .out_full       (out_full)
);

`default_nettype wire

/* grayscale_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module grayscale_tb;

    import image_pkg::*;

    localparam int CLOCK_PERIOD        = 10;
    localparam int RESET_CYCLES        = 16;
    localparam int TABLE_SIZE          = 16;
    localparam int BACKPRESSURE_PIXELS = 2 * FIFO_DEPTH + 1;
    localparam int RANDOM_PIXELS       = SDRAM_DEPTH + 36;
    localparam int RESET_PIXELS        = BACKPRESSURE_PIXELS;
    localparam int PIXEL_CYCLES        = 2 * SDRAM_LATENCY + 10;
    localparam int SETTLE_CYCLES       = (FIFO_DEPTH + 2) * PIXEL_CYCLES;
    localparam int TOTAL_PIXELS        = 2 * TABLE_SIZE + BACKPRESSURE_PIXELS
                                       + RANDOM_PIXELS + RESET_PIXELS;
    localparam int WATCHDOG_CYCLES     = TOTAL_PIXELS * PIXEL_CYCLES + 2 * SETTLE_CYCLES + 1000;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    gray_t  out_dout;
    logic   out_empty;
    logic   drain;
    gray_t  expected [$];

    // Corner colors first, then mixed channels
    pixel_t table_pixel [TABLE_SIZE] = '{
        24'h000000, 24'hFFFFFF, 24'hFF0000, 24'h00FF00,
        24'h0000FF, 24'h102030, 24'h010101, 24'h010100,
        24'h808080, 24'h7F8081, 24'h0A0B0C, 24'hFFFE00,
        24'h123456, 24'hC80064, 24'h030405, 24'hFFFFFE
    };
    gray_t table_gray [TABLE_SIZE] = '{
        8'h00, 8'hFF, 8'h55, 8'h55,
        8'h55, 8'h20, 8'h01, 8'h00,
        8'h80, 8'h80, 8'h0B, 8'hA9,
        8'h34, 8'h64, 8'h04, 8'hFE
    };

    grayscale_top UUT (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    task automatic abort_run;
        $display("Errors found");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic compare_gray(input string name, input gray_t actual, input gray_t want);
        if (actual !== want) begin
            $display("Mismatch at %0t: %s is %02h, expected %02h", $time, name, actual, want);
            abort_run();
        end
    endtask

    task automatic verify_status(input string name, input logic actual, input logic want);
        if (actual !== want) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, want);
            abort_run();
        end
    endtask

    // Gray is the floor of the channel mean
    function automatic gray_t average_gray(input pixel_t pixel);
        int sum;
        sum = int'(pixel.rgb.red) + int'(pixel.rgb.green) + int'(pixel.rgb.blue);
        return gray_t'(sum / 3);
    endfunction

    // Called on a falling edge, returns on the falling edge after the write
    task automatic send_pixel(input pixel_t pixel, input gray_t gray);
        in_wr_en = 1'b0;
        while (in_full) begin
            @(negedge clock);
        end
        in_wr_en = 1'b1;
        in_din   = pixel;
        expected.push_back(gray);
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    task automatic send_random(input int count);
        pixel_t pixel;
        for (int i = 0; i < count; i++) begin
            pixel.raw = 24'($urandom);
            send_pixel(pixel, average_gray(pixel));
        end
    endtask

    task automatic set_drain(input logic value);
        @(posedge clock);
        drain = value;
        @(negedge clock);
    endtask

    task automatic wait_drained;
        while (expected.size() != 0) begin
            @(posedge clock);
        end
        @(negedge clock);
        verify_status("out_empty", out_empty, 1'b1);
    endtask

    task automatic apply_reset;
        reset    = 1'b1;
        in_wr_en = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
    endtask

    // Receiver pops one result per cycle while draining is enabled
    initial begin
        out_rd_en = 1'b0;
        forever begin
            @(negedge clock);
            out_rd_en = 1'b0;
            if (drain && !reset && !out_empty) begin
                if (expected.size() == 0) begin
                    $display("Output %02h at %0t arrived with no pixel pending", out_dout, $time);
                    abort_run();
                end else begin
                    compare_gray("out_dout", out_dout, expected.pop_front());
                    out_rd_en = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout after %0d cycles, the pixel stream did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        in_wr_en = 1'b0;
        in_din   = '0;
        drain    = 1'b0;
        void'($urandom(81915));
        apply_reset();

        // Idle after reset, nothing may come out
        verify_status("out_empty", out_empty, 1'b1);
        verify_status("in_full", in_full, 1'b0);
        repeat (2 * PIXEL_CYCLES) begin
            @(negedge clock);
            verify_status("out_empty", out_empty, 1'b1);
        end

        set_drain(1'b1);
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_pixel(table_pixel[i], table_gray[i]);
        end
        wait_drained();

        // Output FIFO full, one pixel held in the FSM, one input slot still free
        set_drain(1'b0);
        send_random(BACKPRESSURE_PIXELS - 1);
        repeat (SETTLE_CYCLES) @(negedge clock);
        verify_status("in_full", in_full, 1'b0);
        verify_status("out_empty", out_empty, 1'b0);
        send_random(1);
        repeat (SETTLE_CYCLES) @(negedge clock);
        verify_status("in_full", in_full, 1'b1);
        set_drain(1'b1);
        wait_drained();

        // Enough pixels to wrap the memory offset
        send_random(RANDOM_PIXELS);
        wait_drained();

        // Reset with both FIFOs full and one pixel held in the FSM
        set_drain(1'b0);
        send_random(RESET_PIXELS);
        repeat (3 * PIXEL_CYCLES) @(negedge clock);
        verify_status("in_full", in_full, 1'b1);
        verify_status("out_empty", out_empty, 1'b0);
        apply_reset();
        expected.delete();
        verify_status("out_empty", out_empty, 1'b1);
        verify_status("in_full", in_full, 1'b0);
        set_drain(1'b1);
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_pixel(table_pixel[i], table_gray[i]);
        end
        wait_drained();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
image_pkg.sv
pixel_fifo.sv
access_timer.sv
sdram_model.sv
grayscale_fsm.sv
grayscale_top.sv
grayscale_sva.sv
grayscale_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the grayscale testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module grayscale_tb --Mdir obj_dir -o grayscale_sim -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/grayscale_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
